// File: verilog.f
+incdir+verilog
verilog/sdram_ctrl_pkg.sv
verilog/sdram_sequencer.sv
verilog/sdram_datapath.sv
verilog/sdram_cmd_encoder.sv
verilog/sdram_ctrl.sv
test/sdram_chip_model.sv
test/tb_sdram_ctrl.sv

// File: Makefile
# Verilator build and run for the SDRAM controller testbench

VERILATOR ?= verilator
TOP       ?= tb_sdram_ctrl
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Test passed

BIN := $(BUILD_DIR)/V$(TOP)
SRCS := $(wildcard verilog/*.sv verilog/*.svh test/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_sdram_ctrl.sv
/*
 * Testbench for the SDRAM controller. Checks the power-up commands, single
 * reads and writes, the idle refresh and a random access burst against a
 * behavioral chip model.
 */
`timescale 1ns/1ps
`include "sdram_ctrl_defs.svh"

module tb_sdram_ctrl
    import sdram_ctrl_pkg::*;
();

    localparam int timeout_cycles = 100;
    // Cycles until valid returns, one per step of each chain
    localparam int power_up_cycles = 9;
    localparam int read_cycles = 5;
    localparam int write_cycles = 4;
    localparam int refresh_cycles = 6;

    logic                     clk;
    logic                     rst;
    logic                     ready;
    user_cmd_e                cmd;
    user_addr_t               addr;
    logic [`SDRAM_DATA_W-1:0] wr_data;
    logic                     valid;
    logic [`SDRAM_DATA_W-1:0] rd_data;
    logic [`SDRAM_BANK_W-1:0] dram_ba;
    logic [`SDRAM_ROW_W-1:0]  dram_a;
    logic                     dram_ras_n;
    logic                     dram_cas_n;
    logic                     dram_we_n;
    logic                     dram_dqm;
    logic [`SDRAM_DATA_W-1:0] dram_dq_out;
    logic                     dram_dq_oe;
    logic [`SDRAM_DATA_W-1:0] dram_dq_in;

    logic [`SDRAM_DATA_W-1:0] shadow [bit [24:0]];
    logic [`SDRAM_DATA_W-1:0] exp_q [$];
    user_addr_t               pool [6];
    int                       reads_issued = 0;
    int                       reads_checked = 0;
    event                     read_done;

    sdram_ctrl i_dut (.*);
    sdram_chip_model i_chip (.*);

    always #20 clk = ~clk;

    function automatic logic [`SDRAM_DATA_W-1:0] ref_read(input user_addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return a[15:0] ^ {7'h5a, a[24:16]};
    endfunction

    task automatic stop_failed();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string msg);
        $display("mismatch at %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic check_data(input logic [`SDRAM_DATA_W-1:0] got,
                              input logic [`SDRAM_DATA_W-1:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_cmd(input logic [2:0] got, input logic [2:0] exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s command got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    task automatic check_addr(input user_addr_t got, input user_addr_t exp, input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_abus(input sdram_a_bus_u got, input sdram_a_bus_u exp,
                              input string what);
        if (got !== exp) begin
            report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            report_mismatch($sformatf("%s got %0d expected %0d", what, got, exp));
        end
    endtask

    // Busy cycles carry junk commands that the DUT must ignore
    task automatic wait_valid(output int n);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            cmd = valid ? cmd_nop : (($urandom % 2) ? cmd_read : cmd_write);
            addr = 25'($urandom);
            wr_data = 16'($urandom);
            if (n > timeout_cycles) begin
                $display("timeout: valid did not return within %0d cycles", timeout_cycles);
                stop_failed();
            end
        end while (!valid);
    endtask

    task automatic run_op(input user_cmd_e c, input user_addr_t a,
                          input logic [`SDRAM_DATA_W-1:0] d);
        int n;
        int base;
        sdram_a_bus_u act_bus;
        sdram_a_bus_u col_bus;
        base = i_chip.log_cmd.size();
        cmd = c;
        addr = a;
        wr_data = d;
        ready = 1'b1;
        if (c == cmd_write) begin
            shadow[a] = d;
        end else begin
            exp_q.push_back(ref_read(a));
            reads_issued++;
        end
        wait_valid(n);
        // First counted edge is the accepting one
        check_count(n - 1, (c == cmd_read) ? read_cycles : write_cycles, "access latency");
        check_count(i_chip.log_cmd.size() - base, 2, "chip commands per access");
        // RAS_n, CAS_n, WE_n codes from the SDRAM command table
        check_cmd(i_chip.log_cmd[base], 3'b011, "activate");
        check_cmd(i_chip.log_cmd[base+1], (c == cmd_read) ? 3'b101 : 3'b100, "column");
        check_flag(i_chip.log_dqm[base+1], 1'b0, "mask on column command");
        act_bus = i_chip.log_a[base];
        col_bus = i_chip.log_a[base+1];
        check_abus(col_bus, {2'b00, 1'b1, a.col}, "column bus with auto-precharge");
        check_addr({i_chip.log_ba[base], act_bus.row_view, col_bus.col_view.column}, a,
                   "address seen by chip");
        if (c == cmd_read) begin
            -> read_done;
        end
    endtask

    always begin
        @(read_done);
        check_data(rd_data, exp_q.pop_front(), "read data");
        reads_checked++;
    end

    initial begin
        int n;
        int base;
        void'($urandom(32'h10fff606));
        clk = 1'b0;
        rst = 1'b1;
        ready = 1'b0;
        cmd = cmd_nop;
        addr = '0;
        wr_data = '0;
        foreach (pool[i]) begin
            pool[i] = 25'($urandom);
        end
        repeat (16) @(negedge clk);
        rst = 1'b0;
        ready = 1'b1;
        wait_valid(n);
        check_count(n, power_up_cycles, "cycles to valid after reset");
        check_count(i_chip.log_cmd.size(), 4, "power-up commands");
        check_cmd(i_chip.log_cmd[0], 3'b010, "precharge");
        check_cmd(i_chip.log_cmd[1], 3'b001, "first refresh");
        check_cmd(i_chip.log_cmd[2], 3'b001, "second refresh");
        check_cmd(i_chip.log_cmd[3], 3'b000, "load mode");
        check_abus(i_chip.log_a[3], 13'h028, "mode word");
        for (int i = 0; i < 4; i++) begin
            check_flag(i_chip.log_dqm[i], 1'b1, "mask during power-up");
        end

        run_op(cmd_write, pool[0], 16'($urandom));
        run_op(cmd_read, pool[0], '0);
        run_op(cmd_read, 25'($urandom), '0);

        // Count runs 32 down to zero in idle, refresh starts one edge later
        base = i_chip.log_cmd.size();
        ready = 1'b0;
        cmd = cmd_read;
        n = 0;
        do begin
            n++;
            @(negedge clk);
            if (n > timeout_cycles) begin
                $display("timeout: no refresh within %0d idle cycles", timeout_cycles);
                stop_failed();
            end
        end while (valid);
        check_count(n, `SDRAM_REFRESH_IDLE_CYCLES + 1, "idle cycles before refresh");
        wait_valid(n);
        check_count(n, refresh_cycles, "refresh length");
        check_count(i_chip.log_cmd.size() - base, 1, "chip commands in refresh");
        check_cmd(i_chip.log_cmd[base], 3'b001, "idle refresh");
        check_flag(i_chip.log_dqm[base], 1'b1, "mask during refresh");

        for (int i = 0; i < 30; i++) begin
            repeat ($urandom % 6) @(negedge clk);
            run_op(($urandom % 2) ? cmd_write : cmd_read, pool[$urandom % 6], 16'($urandom));
        end
        repeat (2) @(negedge clk);
        check_count(reads_checked, reads_issued, "reads compared");
        $display("Test passed");
        $finish;
    end

endmodule

// File: test/sdram_chip_model.sv
/*
 * Behavioral SDR SDRAM for the controller testbench. Decodes commands on the
 * rising edge, keeps one open row per bank and returns read words after the
 * CAS latency. Each decoded command is logged for the testbench to inspect.
 */
`timescale 1ns/1ps
`include "sdram_ctrl_defs.svh"

module sdram_chip_model
    import sdram_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic [`SDRAM_BANK_W-1:0] dram_ba,
    input  sdram_a_bus_u             dram_a,
    input  logic                     dram_ras_n,
    input  logic                     dram_cas_n,
    input  logic                     dram_we_n,
    input  logic                     dram_dqm,
    input  logic [`SDRAM_DATA_W-1:0] dram_dq_out,
    input  logic                     dram_dq_oe,
    output logic [`SDRAM_DATA_W-1:0] dram_dq_in
);

    logic [`SDRAM_DATA_W-1:0] mem [bit [24:0]];
    logic [`SDRAM_ROW_W-1:0]  open_row [1 << `SDRAM_BANK_W];
    logic [`SDRAM_DATA_W-1:0] rd_pipe [`SDRAM_CAS_LATENCY];
    logic [2:0]               op;
    user_addr_t               word_addr;

    // Command log, one entry per non-NOP command
    logic [2:0]               log_cmd [$];
    logic [`SDRAM_BANK_W-1:0] log_ba [$];
    sdram_a_bus_u             log_a [$];
    logic                     log_dqm [$];

    // Untouched words read back as a pattern of their full address
    function automatic logic [`SDRAM_DATA_W-1:0] fill_word(input bit [24:0] a);
        return a[15:0] ^ {7'h5a, a[24:16]};
    endfunction

    assign op = {dram_ras_n, dram_cas_n, dram_we_n};
    assign word_addr = {dram_ba, open_row[dram_ba], dram_a.col_view.column};
    assign dram_dq_in = rd_pipe[`SDRAM_CAS_LATENCY-1];

    always @(posedge clk) begin
        rd_pipe[0] <= '0;
        for (int i = 1; i < `SDRAM_CAS_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
        if (op != 3'b111) begin
            log_cmd.push_back(op);
            log_ba.push_back(dram_ba);
            log_a.push_back(dram_a);
            log_dqm.push_back(dram_dqm);
        end
        case (op)
            3'b011: open_row[dram_ba] <= dram_a.row_view;
            3'b101: rd_pipe[0] <= mem.exists(word_addr) ? mem[word_addr] : fill_word(word_addr);
            3'b100: begin
                if (dram_dq_oe && !dram_dqm) begin
                    mem[word_addr] = dram_dq_out;
                end
            end
            default: ;
        endcase
    end

endmodule

// File: verilog/sdram_ctrl.sv
/*
 * Top level of the single-port SDR SDRAM controller. User commands are
 * taken while valid is high; the chip side has separate data in, data out
 * and output enable for an external or board-level tristate.
 */
`timescale 1ns/1ps
`include "sdram_ctrl_defs.svh"

module sdram_ctrl
    import sdram_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  user_cmd_e                cmd,
    input  user_addr_t               addr,
    input  logic [`SDRAM_DATA_W-1:0] wr_data,
    input  logic                     ready,
    output logic                     valid,
    output logic [`SDRAM_DATA_W-1:0] rd_data,

    output logic [`SDRAM_BANK_W-1:0] dram_ba,
    output logic [`SDRAM_ROW_W-1:0]  dram_a,
    output logic                     dram_ras_n,
    output logic                     dram_cas_n,
    output logic                     dram_we_n,
    output logic                     dram_dqm,
    output logic [`SDRAM_DATA_W-1:0] dram_dq_out,
    output logic                     dram_dq_oe,
    input  logic [`SDRAM_DATA_W-1:0] dram_dq_in
);

    sdram_step_e step;
    logic        accept;
    user_addr_t  addr_q;

    sdram_sequencer i_sequencer (
        .clk    (clk),
        .rst    (rst),
        .ready  (ready),
        .cmd    (cmd),
        .step   (step),
        .accept (accept),
        .valid  (valid)
    );

    sdram_datapath i_datapath (
        .clk         (clk),
        .rst         (rst),
        .accept      (accept),
        .step        (step),
        .addr        (addr),
        .wr_data     (wr_data),
        .dram_dq_in  (dram_dq_in),
        .addr_q      (addr_q),
        .dram_dq_out (dram_dq_out),
        .rd_data     (rd_data)
    );

    sdram_cmd_encoder i_encoder (
        .step       (step),
        .addr_q     (addr_q),
        .dram_ba    (dram_ba),
        .dram_a     (dram_a),
        .dram_ras_n (dram_ras_n),
        .dram_cas_n (dram_cas_n),
        .dram_we_n  (dram_we_n),
        .dram_dqm   (dram_dqm),
        .dram_dq_oe (dram_dq_oe)
    );

endmodule

// File: verilog/sdram_cmd_encoder.sv
/*
 * Combinational decode of the current step into SDRAM command pins, bank
 * and address bus, data mask and write-data enable.
 */
`timescale 1ns/1ps
`include "sdram_ctrl_defs.svh"

module sdram_cmd_encoder
    import sdram_ctrl_pkg::*;
(
    input  sdram_step_e              step,
    input  user_addr_t               addr_q,
    output logic [`SDRAM_BANK_W-1:0] dram_ba,
    output logic [`SDRAM_ROW_W-1:0]  dram_a,
    output logic                     dram_ras_n,
    output logic                     dram_cas_n,
    output logic                     dram_we_n,
    output logic                     dram_dqm,
    output logic                     dram_dq_oe
);

    // RAS_n, CAS_n, WE_n
    localparam logic [2:0] sdr_nop       = 3'b111;
    localparam logic [2:0] sdr_active    = 3'b011;
    localparam logic [2:0] sdr_read      = 3'b101;
    localparam logic [2:0] sdr_write     = 3'b100;
    localparam logic [2:0] sdr_precharge = 3'b010;
    localparam logic [2:0] sdr_refresh   = 3'b001;
    localparam logic [2:0] sdr_load_mode = 3'b000;

    logic [2:0]   cmd_code;
    sdram_a_bus_u a_bus;
    logic         power_up;

    assign power_up = step inside {st_reset, st_init_nop0, st_init_precharge,
                                   st_init_ref0, st_init_nop1, st_init_ref1,
                                   st_init_nop2, st_init_load, st_init_nop3};

    // Mask stays up until the chip is configured and around the refresh
    assign dram_dqm = power_up || (step == st_ref_auto);

    always_comb begin
        cmd_code = sdr_nop;
        dram_ba = '0;
        a_bus = '0;
        dram_dq_oe = 1'b0;
        case (step)
            st_init_precharge: begin
                cmd_code = sdr_precharge;
                // A10 high selects all banks
                a_bus.col_view.auto_pre = 1'b1;
            end
            st_init_ref0, st_init_ref1, st_ref_auto: begin
                cmd_code = sdr_refresh;
            end
            st_init_load: begin
                cmd_code = sdr_load_mode;
                a_bus.row_view = `SDRAM_MODE_WORD;
            end
            st_rd_active, st_wr_active: begin
                cmd_code = sdr_active;
                dram_ba = addr_q.bank;
                a_bus.row_view = addr_q.row;
            end
            st_rd_cmd: begin
                cmd_code = sdr_read;
                dram_ba = addr_q.bank;
                a_bus.col_view.auto_pre = 1'b1;
                a_bus.col_view.column = addr_q.col;
            end
            st_wr_cmd: begin
                cmd_code = sdr_write;
                dram_ba = addr_q.bank;
                a_bus.col_view.auto_pre = 1'b1;
                a_bus.col_view.column = addr_q.col;
                dram_dq_oe = 1'b1;
            end
            default: begin
                cmd_code = sdr_nop;
            end
        endcase
    end

    assign {dram_ras_n, dram_cas_n, dram_we_n} = cmd_code;
    assign dram_a = a_bus;

endmodule

// File: verilog/sdram_datapath.sv
/*
 * Data side of the SDRAM controller. Holds the address and write word of
 * the accepted command for the whole operation and captures the read word
 * from the chip in the read data step.
 */
`timescale 1ns/1ps
`include "sdram_ctrl_defs.svh"

module sdram_datapath
    import sdram_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     accept,
    input  sdram_step_e              step,
    input  user_addr_t               addr,
    input  logic [`SDRAM_DATA_W-1:0] wr_data,
    input  logic [`SDRAM_DATA_W-1:0] dram_dq_in,
    output user_addr_t               addr_q,
    output logic [`SDRAM_DATA_W-1:0] dram_dq_out,
    output logic [`SDRAM_DATA_W-1:0] rd_data
);

    // User inputs may change right after the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= addr;
            dram_dq_out <= wr_data;
        end
    end

    // Chip drives the word CAS latency after the read command
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_data <= '0;
        end else if (step == st_rd_data) begin
            rd_data <= dram_dq_in;
        end
    end

endmodule

// File: verilog/sdram_sequencer.sv
/*
 * Step machine of the SDRAM controller. Walks the power-up chain after
 * reset, then waits in idle for single-word reads and writes and starts
 * an auto-refresh after a fixed run of idle cycles.
 */
`timescale 1ns/1ps
`include "sdram_ctrl_defs.svh"

module sdram_sequencer
    import sdram_ctrl_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        ready,
    input  user_cmd_e   cmd,
    output sdram_step_e step,
    output logic        accept,
    output logic        valid
);

    localparam int refresh_cnt_w = $clog2(`SDRAM_REFRESH_IDLE_CYCLES + 1);

    sdram_step_e              step_next;
    logic [refresh_cnt_w-1:0] refresh_cnt;
    logic                     take_read;
    logic                     take_write;
    logic                     refresh_due;

    assign valid = (step == st_idle);

    // Read has priority over write
    assign take_read = valid && ready && (cmd == cmd_read);
    assign take_write = valid && ready && (cmd == cmd_write);
    assign accept = take_read || take_write;

    assign refresh_due = (refresh_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            step <= st_reset;
        end else begin
            step <= step_next;
        end
    end

    // Reloads on every non-idle step, so only consecutive idle cycles count
    always_ff @(posedge clk) begin
        if (rst || step != st_idle) begin
            refresh_cnt <= refresh_cnt_w'(`SDRAM_REFRESH_IDLE_CYCLES);
        end else begin
            refresh_cnt <= refresh_cnt - 1'b1;
        end
    end

    always_comb begin
        case (step)
            // Power-up chain
            st_reset:          step_next = st_init_nop0;
            st_init_nop0:      step_next = st_init_precharge;
            st_init_precharge: step_next = st_init_ref0;
            st_init_ref0:      step_next = st_init_nop1;
            st_init_nop1:      step_next = st_init_ref1;
            st_init_ref1:      step_next = st_init_nop2;
            st_init_nop2:      step_next = st_init_load;
            st_init_load:      step_next = st_init_nop3;
            st_init_nop3:      step_next = st_idle;

            st_rd_initial:     step_next = st_rd_active;
            st_rd_active:      step_next = st_rd_cmd;
            st_rd_cmd:         step_next = st_rd_nop;
            st_rd_nop:         step_next = st_rd_data;
            st_rd_data:        step_next = st_idle;

            st_wr_initial:     step_next = st_wr_active;
            st_wr_active:      step_next = st_wr_cmd;
            st_wr_cmd:         step_next = st_wr_nop;
            st_wr_nop:         step_next = st_idle;

            // Refresh has its own chain and never revisits power-up
            st_ref_initial:    step_next = st_ref_nop0;
            st_ref_nop0:       step_next = st_ref_auto;
            st_ref_auto:       step_next = st_ref_nop1;
            st_ref_nop1:       step_next = st_ref_nop2;
            st_ref_nop2:       step_next = st_ref_done;
            st_ref_done:       step_next = st_idle;

            st_idle: begin
                if (take_read) begin
                    step_next = st_rd_initial;
                end else if (take_write) begin
                    step_next = st_wr_initial;
                end else if (refresh_due) begin
                    step_next = st_ref_initial;
                end else begin
                    step_next = st_idle;
                end
            end

            default:           step_next = st_reset;
        endcase
    end

endmodule

// File: verilog/sdram_ctrl_pkg.sv
/*
 * Types shared by the SDRAM controller blocks and the testbench.
 * Import with a wildcard in the module header.
 */
`include "sdram_ctrl_defs.svh"

package sdram_ctrl_pkg;

    // User command code
    typedef enum logic [1:0] {
        cmd_nop   = 2'b00,
        cmd_read  = 2'b01,
        cmd_write = 2'b10
    } user_cmd_e;

    typedef enum logic [4:0] {
        st_reset,
        st_init_nop0,
        st_init_precharge,
        st_init_ref0,
        st_init_nop1,
        st_init_ref1,
        st_init_nop2,
        st_init_load,
        st_init_nop3,
        st_rd_initial,
        st_rd_active,
        st_rd_cmd,
        st_rd_nop,
        st_rd_data,
        st_wr_initial,
        st_wr_active,
        st_wr_cmd,
        st_wr_nop,
        st_ref_initial,
        st_ref_nop0,
        st_ref_auto,
        st_ref_nop1,
        st_ref_nop2,
        st_ref_done,
        st_idle
    } sdram_step_e;

    // User word address, bank in the top bits
    typedef struct packed {
        logic [`SDRAM_BANK_W-1:0] bank;
        logic [`SDRAM_ROW_W-1:0]  row;
        logic [`SDRAM_COL_W-1:0]  col;
    } user_addr_t;

    // Column command layout, A10 selects auto-precharge
    typedef struct packed {
        logic [`SDRAM_ROW_W-`SDRAM_COL_W-2:0] spare;
        logic                                 auto_pre;
        logic [`SDRAM_COL_W-1:0]              column;
    } sdram_col_view_t;

    typedef union packed {
        logic [`SDRAM_ROW_W-1:0] row_view;
        sdram_col_view_t         col_view;
    } sdram_a_bus_u;

endpackage

// File: verilog/sdram_ctrl_defs.svh
/*
 * Chip dimensions, refresh interval and mode register value for the SDRAM
 * controller. Include in any package or module that needs them.
 */
`ifndef SDRAM_CTRL_DEFS_SVH
`define SDRAM_CTRL_DEFS_SVH

// Chip geometry for 4 banks of 8K rows by 1K columns
`define SDRAM_BANK_W 2
`define SDRAM_ROW_W 13
`define SDRAM_COL_W 10

// Data bus width
`define SDRAM_DATA_W 16

// Idle cycles before an auto-refresh is forced
`define SDRAM_REFRESH_IDLE_CYCLES 32

// Read latency in clocks
`define SDRAM_CAS_LATENCY 2

// Mode register word: write burst mode and op mode zero, CAS latency in
// A6..A4, interleaved burst type on A3, burst length 1 in A2..A0
`define SDRAM_MODE_WORD {6'b000000, 3'(`SDRAM_CAS_LATENCY), 1'b1, 3'b000}

`endif
